// ==== verification/concat_vectors.txt ====
# S valid_a in_a valid_b in_b cycles : drive inputs, data counts up per write, then one idle cycle
# E first_word count | Q out_word (valid_out low) | O overflow | G burst | C compare | R reset
# 1 empty fifos after reset
S 0 00000000 0 00000000 6
Q 00000000
O 0
# 2 one pixel, A words then B words
E a0000000 8
E b0000000 2
S 1 a0000000 0 00000000 8
S 0 00000000 1 b0000000 2
S 0 00000000 0 00000000 16
C
G 10
# 3 B arrives first and waits for the eighth A word
R
E a0000010 8
E b0000010 2
S 0 00000000 1 b0000010 2
S 1 a0000010 0 00000000 7
S 0 00000000 0 00000000 4
Q 00000000
S 1 a0000017 0 00000000 1
S 0 00000000 0 00000000 14
C
# 4 two pixels back to back
R
E a0000020 8
E b0000020 2
E a0000028 8
E b0000022 2
S 1 a0000020 1 b0000020 4
S 1 a0000024 0 00000000 12
S 0 00000000 0 00000000 26
C
G 20
# 5 seventeen A writes overflow the fifo, reset clears it
R
S 1 c0000000 0 00000000 16
O 0
S 1 c0000010 0 00000000 1
O 1
R
O 0
Q 00000000

// ==== list.f ====
logic/cnn_concat_pkg.sv
logic/channel_fifo.sv
logic/concat_sequencer.sv
logic/cnn_concat_2in.sv
verification/tb_cnn_concat.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the concat testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module tb_cnn_concat -o sim_cnn_concat

./obj_dir/sim_cnn_concat | tee sim.log

if grep -q "^Simulation PASSED$" sim.log; then
  echo "run_sim: pass"
else
  echo "run_sim: fail, see sim.log"
  exit 1
fi

// ==== verification/tb_cnn_concat.sv ====
module tb_cnn_concat;
  timeunit 1ns;
  timeprecision 1ps;
  import cnn_concat_pkg::*;

  localparam int    CH_A         = 8;
  localparam int    CH_B         = 2;
  localparam int    FIFO_DEPTH   = 16;
  localparam int    RESET_CYCLES = 8;
  localparam string VEC_FILE     = "verification/concat_vectors.txt";

  logic                  clk;
  logic                  reset;
  logic                  valid_a;
  logic [DATA_WIDTH-1:0] in_a;
  logic                  valid_b;
  logic [DATA_WIDTH-1:0] in_b;
  logic [DATA_WIDTH-1:0] out;
  logic                  valid_out;
  logic                  overflow;

  string                 lines[$];
  logic [DATA_WIDTH-1:0] exp_q[$];
  logic [DATA_WIDTH-1:0] got_q[$];
  time                   got_t[$];
  int                    got_idx;
  int                    run_len = 0;
  int                    last_run = 0;
  int                    cycles = 0;
  int                    cycle_limit = 0;
  int                    value_errors;
  int                    other_errors;

  cnn_concat_2in #(
    .CH_A       (CH_A),
    .CH_B       (CH_B),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) DUT (
    .clk       (clk),
    .reset     (reset),
    .valid_a   (valid_a),
    .in_a      (in_a),
    .valid_b   (valid_b),
    .in_b      (in_b),
    .out       (out),
    .valid_out (valid_out),
    .overflow  (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // output capture and watchdog
  //////////////////////////////////////////////////////////////////////

  // every valid word in arrival order, plus the length of the last burst
  always @(posedge clk) begin
    if (reset) begin
      run_len <= 0;
    end else if (valid_out) begin
      got_q.push_back(out);
      got_t.push_back($time);
      run_len <= run_len + 1;
    end else if (run_len != 0) begin
      last_run <= run_len;
      run_len  <= 0;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the vectors never finished", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                             input logic [DATA_WIDTH-1:0] actual, input time at);
    if (actual !== expected) begin
      value_errors++;
      $display("[ERROR] t=%0t %s expected %h got %h", at, name, expected, actual);
    end
  endtask

  // data words count up on every cycle in which their strobe is set
  task automatic drive_cycles(input logic va, input logic [DATA_WIDTH-1:0] a,
                              input logic vb, input logic [DATA_WIDTH-1:0] b, input int n);
    logic [DATA_WIDTH-1:0] da;
    logic [DATA_WIDTH-1:0] db;
    da = a;
    db = b;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      valid_a <= va;
      in_a    <= da;
      valid_b <= vb;
      in_b    <= db;
      if (va) da = da + DATA_WIDTH'(1);
      if (vb) db = db + DATA_WIDTH'(1);
    end
    @(posedge clk);
    valid_a <= 1'b0;
    in_a    <= '0;
    valid_b <= 1'b0;
    in_b    <= '0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset   <= 1'b1;
    valid_a <= 1'b0;
    valid_b <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic compare_outputs();
    while (exp_q.size() > 0 && got_idx < got_q.size()) begin
      check_value("out", exp_q.pop_front(), got_q[got_idx], got_t[got_idx]);
      got_idx++;
    end
    if (exp_q.size() > 0) begin
      other_errors++;
      $display("missing output: %0d expected words never came out", exp_q.size());
      exp_q.delete();
    end
    if (got_idx < got_q.size()) begin
      other_errors++;
      $display("unexpected output: %0d words beyond the expected list", got_q.size() - got_idx);
      got_idx = got_q.size();
    end
  endtask

  // keeps the records and sizes the watchdog from the stimulus length
  task automatic load_vectors();
    int                    fd;
    int                    rep;
    byte                   code;
    string                 line;
    logic [DATA_WIDTH-1:0] f0, f1, f2, f3;
    cycle_limit = RESET_CYCLES + 50;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      other_errors++;
      $display("cannot open the vectors file %s", VEC_FILE);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) > 1) begin
        code = line.getc(0);
        if (code != "#") begin
          lines.push_back(line);
          if (code == "S" && $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %d",
                                     f0, f1, f2, f3, rep) == 5) begin
            cycle_limit += rep + 1;
          end else if (code == "R") begin
            cycle_limit += RESET_CYCLES + 1;
          end
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_record(input string line);
    byte                   code;
    string                 rest;
    int                    rep;
    logic [DATA_WIDTH-1:0] f0, f1, f2, f3;
    code = line.getc(0);
    rest = line.substr(1, line.len() - 1);
    case (code)
      "S": begin
        if ($sscanf(rest, "%h %h %h %h %d", f0, f1, f2, f3, rep) == 5) begin
          drive_cycles(f0[0], f1, f2[0], f3, rep);
        end
      end
      "E": begin
        if ($sscanf(rest, "%h %d", f0, rep) == 2) begin
          for (int k = 0; k < rep; k++) exp_q.push_back(f0 + DATA_WIDTH'(k));
        end
      end
      "R": apply_reset();
      "C": compare_outputs();
      "O": begin
        void'($sscanf(rest, "%h", f0));
        @(negedge clk);
        check_value("overflow", f0, DATA_WIDTH'(overflow), $time);
      end
      "Q": begin
        void'($sscanf(rest, "%h", f0));
        @(negedge clk);
        check_value("valid_out", '0, DATA_WIDTH'(valid_out), $time);
        check_value("out", f0, out, $time);
      end
      "G": begin
        void'($sscanf(rest, "%d", f0));
        check_value("burst_length", f0, DATA_WIDTH'(last_run), $time);
      end
      default: begin
        other_errors++;
        $display("unknown record in the vectors file: %s", line);
      end
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    reset        = 1'b1;
    valid_a      = 1'b0;
    in_a         = '0;
    valid_b      = 1'b0;
    in_b         = '0;
    got_idx      = 0;
    value_errors = 0;
    other_errors = 0;
    load_vectors();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    foreach (lines[i]) run_record(lines[i]);
    @(posedge clk);
    compare_outputs();
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== logic/cnn_concat_2in.sv ====
module cnn_concat_2in #(
  parameter int CH_A       = 8,
  parameter int CH_B       = 2,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  valid_a,
  input  logic [cnn_concat_pkg::DATA_WIDTH-1:0] in_a,
  input  logic                                  valid_b,
  input  logic [cnn_concat_pkg::DATA_WIDTH-1:0] in_b,
  output logic [cnn_concat_pkg::DATA_WIDTH-1:0] out,
  output logic                                  valid_out,
  output logic                                  overflow
);
  import cnn_concat_pkg::*;

  localparam int CNT_W = cnt_width(FIFO_DEPTH);

  logic [CNT_W-1:0]      count_a;
  logic [CNT_W-1:0]      count_b;
  logic [DATA_WIDTH-1:0] dout_a;
  logic [DATA_WIDTH-1:0] dout_b;
  logic                  rd_a;
  logic                  rd_b;
  logic                  overflow_a;
  logic                  overflow_b;

  // a pixel has to fit in each fifo
  if ((FIFO_DEPTH < CH_A) || (FIFO_DEPTH < CH_B)) begin : g_depth_too_small
    $error("cnn_concat_2in: FIFO_DEPTH smaller than a pixel");
  end

  if ((FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : g_depth_not_pow2
    $error("cnn_concat_2in: FIFO_DEPTH must be a power of two");
  end

  //////////////////////////////////////////////////////////////////////
  // input buffering, one fifo per stream
  //////////////////////////////////////////////////////////////////////

  channel_fifo #(.DEPTH(FIFO_DEPTH)) fifo_a (
    .clk      (clk),
    .reset    (reset),
    .wr_en    (valid_a),
    .din      (in_a),
    .rd_en    (rd_a),
    .dout     (dout_a),
    .count    (count_a),
    .overflow (overflow_a)
  );

  channel_fifo #(.DEPTH(FIFO_DEPTH)) fifo_b (
    .clk      (clk),
    .reset    (reset),
    .wr_en    (valid_b),
    .din      (in_b),
    .rd_en    (rd_b),
    .dout     (dout_b),
    .count    (count_b),
    .overflow (overflow_b)
  );

  //////////////////////////////////////////////////////////////////////
  // pixel sequencer
  //////////////////////////////////////////////////////////////////////

  concat_sequencer #(
    .CH_A  (CH_A),
    .CH_B  (CH_B),
    .CNT_W (CNT_W)
  ) u_sequencer (
    .clk       (clk),
    .reset     (reset),
    .count_a   (count_a),
    .count_b   (count_b),
    .data_a    (dout_a),
    .data_b    (dout_b),
    .rd_a      (rd_a),
    .rd_b      (rd_b),
    .out       (out),
    .valid_out (valid_out)
  );

  // either stream dropping a word
  assign overflow = overflow_a | overflow_b;

endmodule

// ==== logic/concat_sequencer.sv ====
module concat_sequencer #(
  parameter int CH_A  = 8,
  parameter int CH_B  = 2,
  parameter int CNT_W = 5
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [CNT_W-1:0]                      count_a,
  input  logic [CNT_W-1:0]                      count_b,
  input  logic [cnn_concat_pkg::DATA_WIDTH-1:0] data_a,
  input  logic [cnn_concat_pkg::DATA_WIDTH-1:0] data_b,
  output logic                                  rd_a,
  output logic                                  rd_b,
  output logic [cnn_concat_pkg::DATA_WIDTH-1:0] out,
  output logic                                  valid_out
);
  import cnn_concat_pkg::*;

  localparam int CH_MAX = (CH_A > CH_B) ? CH_A : CH_B;
  localparam int WC_W   = $clog2(CH_MAX + 1);

  seq_state_t      state;
  seq_state_t      state_next;
  logic [WC_W-1:0] word_cnt;
  logic            pixel_ready;
  logic            next_ready;
  logic            last_a;
  logic            last_b;
  logic            rd_d1;
  logic            sel_b_d1;

  //////////////////////////////////////////////////////////////////////
  // pixel availability
  //////////////////////////////////////////////////////////////////////

  // one whole pixel waiting on both streams
  assign pixel_ready = (count_a >= CNT_W'(CH_A)) && (count_b >= CNT_W'(CH_B));

  // on the last B read that word still sits in count_b
  assign next_ready = (count_a >= CNT_W'(CH_A)) && (count_b >= CNT_W'(CH_B + 1));

  assign rd_a   = (state == ST_READ_A);
  assign rd_b   = (state == ST_READ_B);
  assign last_a = rd_a && (word_cnt == WC_W'(CH_A - 1));
  assign last_b = rd_b && (word_cnt == WC_W'(CH_B - 1));

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (pixel_ready) begin
          state_next = ST_READ_A;
        end
      end
      ST_READ_A: begin
        if (last_a) begin
          state_next = ST_READ_B;
        end
      end
      ST_READ_B: begin
        // back to back pixels skip idle
        if (last_b) begin
          state_next = next_ready ? ST_READ_A : ST_IDLE;
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ST_IDLE;
      word_cnt <= '0;
    end else begin
      state <= state_next;
      if (last_a || last_b) begin
        word_cnt <= '0;
      end else if (rd_a || rd_b) begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output pipeline
  //////////////////////////////////////////////////////////////////////

  // stage 1 tracks the fifo read register and stage 2 is the output register
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_d1     <= 1'b0;
      sel_b_d1  <= 1'b0;
      valid_out <= 1'b0;
      out       <= '0;
    end else begin
      rd_d1     <= rd_a || rd_b;
      sel_b_d1  <= rd_b;
      valid_out <= rd_d1;
      if (rd_d1) begin
        out <= sel_b_d1 ? data_b : data_a;
      end
    end
  end

endmodule

// ==== logic/channel_fifo.sv ====
module channel_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                                        wr_en,
  input  logic [cnn_concat_pkg::DATA_WIDTH-1:0]       din,
  input  logic                                        rd_en,
  output logic [cnn_concat_pkg::DATA_WIDTH-1:0]       dout,
  output logic [cnn_concat_pkg::cnt_width(DEPTH)-1:0] count,
  output logic                                        overflow
);
  import cnn_concat_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = cnt_width(DEPTH);

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic                  full;
  logic                  empty;
  logic                  wr_ok;
  logic                  rd_ok;

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);
  assign rd_ok = rd_en && !empty;
  // a pop in the same cycle frees the slot that a write on full needs
  assign wr_ok = wr_en && (!full || rd_ok);

  //////////////////////////////////////////////////////////////////////
  // storage and registered read port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
    // popped word shows on dout the cycle after rd_en
    if (rd_ok) begin
      dout <= mem[rd_ptr];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pointers, occupancy, overflow
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      // pointers wrap on their own, depth is a power of two
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // dropped write, held until reset
      if (wr_en && full && !rd_ok) begin
        overflow <= 1'b1;
      end
    end
  end

  // sequencer must only pop words that are there
  a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
    rd_en |-> (count != '0))
    else $error("channel_fifo: read while empty");

  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    count <= CNT_W'(DEPTH))
    else $error("channel_fifo: occupancy above depth");

endmodule

// ==== logic/cnn_concat_pkg.sv ====
package cnn_concat_pkg;

  //////////////////////////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////////////////////////

  // width of one channel word on every stream
  localparam int DATA_WIDTH = 32;

  //////////////////////////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////////////////////////

  // idle, then draining the A words of a pixel, then the B words
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_READ_A = 2'd1,
    ST_READ_B = 2'd2
  } seq_state_t;

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // bits needed for an occupancy of 0 up to depth
  function automatic int cnt_width(input int depth);
    return $clog2(depth + 1);
  endfunction

endpackage
